//--- Bender.yml
package:
  name: smu_ctrl

sources:
  - common/smu_pkg.sv
  - spi_front/spi_sync.sv
  - spi_front/spi_frame_rx.sv
  - source/reg_bank.sv
  - source/spi_route.sv
  - source/smu_ctrl_top.sv
  - target: test
    files:
      - testbench/smu_checker.sv
      - testbench/tb_smu_ctrl.sv

//--- common/smu_pkg.sv
/*
 * shared package for the smu spi front end
 * register addresses, reset values, frame union, control register struct
 */
package smu_pkg;

  ////////////////////
  // frame geometry

  // bits per spi frame, high byte address, low byte set/clear
  localparam int FRAME_BITS = 16;
  // downstream peripherals: adc03, dac, flash, adc02
  localparam int N_PERIPH = 4;

  ////////////////////
  // register map

  localparam logic [7:0] ADDR_LED          = 8'd7;
  localparam logic [7:0] ADDR_MUX          = 8'd8;
  localparam logic [7:0] ADDR_DAC          = 8'd9;
  localparam logic [7:0] ADDR_RAILS        = 8'd10;
  // write here reloads every register
  localparam logic [7:0] ADDR_SOFT_RESET   = 8'd11;
  localparam logic [7:0] ADDR_DAC_REF_MUX  = 8'd12;
  localparam logic [7:0] ADDR_ADC          = 8'd14;
  localparam logic [7:0] ADDR_CLAMP1       = 8'd15;
  localparam logic [7:0] ADDR_CLAMP2       = 8'd16;
  localparam logic [7:0] ADDR_IRANGE_SENSE = 8'd20;
  localparam logic [7:0] ADDR_RAILS_OE     = 8'd24;

  ////////////////////
  // frame decode

  // command view of a received word
  // a bit in both nibbles toggles
  typedef struct packed {
    logic [7:0] addr;
    logic [3:0] clr;
    logic [3:0] set;
  } cmd_t;

  // same 16 bits, raw for shifting, cmd for decode
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    cmd_t                  cmd;
  } frame_t;

  ////////////////////
  // control registers

  // led first, so it sits in the top nibble
  typedef struct packed {
    logic [3:0] led;
    logic [3:0] mux;
    logic [3:0] dac;
    logic [3:0] rails;
    logic [3:0] dac_ref_mux;
    logic [3:0] adc;
    logic [3:0] clamp1;
    logic [3:0] clamp2;
    logic [3:0] irange_sense;
    logic [3:0] rails_oe;
  } ctrl_regs_t;

  // clamps and irange sense are active low, keep them off
  // rails_oe bit 0 holds the rails disabled until the mcu is ready
  localparam ctrl_regs_t CTRL_RESET = '{
    led:          4'h0,
    mux:          4'h0,
    dac:          4'h0,
    rails:        4'h0,
    dac_ref_mux:  4'h0,
    adc:          4'h0,
    clamp1:       4'hf,
    clamp2:       4'hf,
    irange_sense: 4'hf,
    rails_oe:     4'h1
  };

endpackage

//--- source/reg_bank.sv
/*
 * control register bank
 * set/clear/toggle update, soft reset, readback lookup by address
 */
module reg_bank (
  input  logic                clk,
  input  logic                arst_n,
  input  smu_pkg::frame_t     frame,
  input  logic                frame_valid,
  input  logic [7:0]          addr_peek,
  output logic [3:0]          rd_nibble,
  output smu_pkg::ctrl_regs_t ctrl
);

  import smu_pkg::*;

  ctrl_regs_t ctrl_q;
  cmd_t       cmd;

  // decode the word through the command view
  assign cmd = frame.cmd;

  // overlap of set and clear toggles just those bits
  // otherwise set first and then clear
  function automatic logic [3:0] update(
    input logic [3:0] cur,
    input logic [3:0] set,
    input logic [3:0] clr
  );
    logic [3:0] both;
    both = set & clr;
    if (both != 4'h0)
      update = cur ^ both;
    else
      update = (cur | set) & ~clr;
  endfunction

  ////////////////////
  // register update

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ctrl_q <= CTRL_RESET;
    else if (frame_valid)
    begin
      case (cmd.addr)
        ADDR_LED:          ctrl_q.led          <= update(ctrl_q.led, cmd.set, cmd.clr);
        ADDR_MUX:          ctrl_q.mux          <= update(ctrl_q.mux, cmd.set, cmd.clr);
        ADDR_DAC:          ctrl_q.dac          <= update(ctrl_q.dac, cmd.set, cmd.clr);
        ADDR_RAILS:        ctrl_q.rails        <= update(ctrl_q.rails, cmd.set, cmd.clr);
        // whole bank back to power-on values
        ADDR_SOFT_RESET:   ctrl_q              <= CTRL_RESET;
        ADDR_DAC_REF_MUX:
          ctrl_q.dac_ref_mux <= update(ctrl_q.dac_ref_mux, cmd.set, cmd.clr);
        ADDR_ADC:          ctrl_q.adc          <= update(ctrl_q.adc, cmd.set, cmd.clr);
        ADDR_CLAMP1:       ctrl_q.clamp1       <= update(ctrl_q.clamp1, cmd.set, cmd.clr);
        ADDR_CLAMP2:       ctrl_q.clamp2       <= update(ctrl_q.clamp2, cmd.set, cmd.clr);
        ADDR_IRANGE_SENSE:
          ctrl_q.irange_sense <= update(ctrl_q.irange_sense, cmd.set, cmd.clr);
        ADDR_RAILS_OE:     ctrl_q.rails_oe     <= update(ctrl_q.rails_oe, cmd.set, cmd.clr);
        // unknown address changes nothing
        default:           ctrl_q              <= ctrl_q;
      endcase
    end
  end

  assign ctrl = ctrl_q;

  ////////////////////
  // readback

  // current value of the register being addressed mid-frame
  always_comb
  begin
    case (addr_peek)
      ADDR_LED:          rd_nibble = ctrl_q.led;
      ADDR_MUX:          rd_nibble = ctrl_q.mux;
      ADDR_DAC:          rd_nibble = ctrl_q.dac;
      ADDR_RAILS:        rd_nibble = ctrl_q.rails;
      ADDR_DAC_REF_MUX:  rd_nibble = ctrl_q.dac_ref_mux;
      ADDR_ADC:          rd_nibble = ctrl_q.adc;
      ADDR_CLAMP1:       rd_nibble = ctrl_q.clamp1;
      ADDR_CLAMP2:       rd_nibble = ctrl_q.clamp2;
      ADDR_IRANGE_SENSE: rd_nibble = ctrl_q.irange_sense;
      ADDR_RAILS_OE:     rd_nibble = ctrl_q.rails_oe;
      // soft reset and unmapped read back as zero
      default:           rd_nibble = 4'h0;
    endcase
  end

  // a consumed frame carries sixteen known bits
  a_frame_known: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |-> !$isunknown(frame.raw))
    else $error("frame consumed with unknown bits");

endmodule

//--- source/smu_ctrl_top.sv
/*
 * top level of the smu spi control front end
 * synchronizer, frame receiver, register bank and spi routing
 */
module smu_ctrl_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         sclk,
  input  logic                         cs,
  input  logic                         special,
  input  logic                         mosi,
  output logic                         miso,
  output logic [smu_pkg::N_PERIPH-1:0] cs_vec,
  input  logic [smu_pkg::N_PERIPH-1:0] miso_vec,
  output smu_pkg::ctrl_regs_t          ctrl
);

  import smu_pkg::*;

  // synchronized pins and edges
  logic   sclk_rise;
  logic   sclk_fall;
  logic   cs_rise;
  logic   cs_q;
  logic   special_q;
  logic   mosi_q;
  // receiver to bank
  frame_t frame;
  logic   frame_valid;
  logic [7:0] addr_peek;
  logic [3:0] rd_nibble;
  // controller readback bit
  logic   sdo;

  ////////////////////
  // front end

  spi_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_spi_sync (
    .clk       (clk),
    .arst_n    (arst_n),
    .sclk      (sclk),
    .cs        (cs),
    .special   (special),
    .mosi      (mosi),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .cs_rise   (cs_rise),
    .cs_q      (cs_q),
    .special_q (special_q),
    .mosi_q    (mosi_q)
  );

  spi_frame_rx u_spi_frame_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .cs_rise     (cs_rise),
    .cs_q        (cs_q),
    .special_q   (special_q),
    .mosi_q      (mosi_q),
    .rd_nibble   (rd_nibble),
    .addr_peek   (addr_peek),
    .sdo         (sdo),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  ////////////////////
  // registers

  reg_bank u_reg_bank (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .addr_peek   (addr_peek),
    .rd_nibble   (rd_nibble),
    .ctrl        (ctrl)
  );

  ////////////////////
  // routing

  // raw pins here, the peripherals see cs with no clk delay
  spi_route u_spi_route (
    .mux      (ctrl.mux),
    .cs       (cs),
    .special  (special),
    .sdo      (sdo),
    .miso_vec (miso_vec),
    .cs_vec   (cs_vec),
    .miso     (miso)
  );

endmodule

//--- source/spi_route.sv
/*
 * chip select fan-out and miso select
 * controller sdo or the miso of the peripherals picked by mux
 */
module spi_route (
  input  logic [3:0]                  mux,
  input  logic                        cs,
  input  logic                        special,
  input  logic                        sdo,
  input  logic [smu_pkg::N_PERIPH-1:0] miso_vec,
  output logic [smu_pkg::N_PERIPH-1:0] cs_vec,
  output logic                        miso
);

  import smu_pkg::*;

  logic route_on;

  // frame passes to the peripherals only with special high and cs low
  // keeps them off the bus while the controller itself is addressed
  assign route_on = special & ~cs;

  ////////////////////
  // chip select

  // active low with only the mux bits following cs
  assign cs_vec = ~(mux & {N_PERIPH{route_on}});

  ////////////////////
  // miso

  // peripherals not selected are masked off before the or
  always_comb
  begin
    if (!special)
      miso = sdo;
    else
      miso = |(mux & miso_vec);
  end

endmodule

//--- spi_front/spi_frame_rx.sv
/*
 * spi frame receiver in the clk domain
 * shift register, saturating bit counter, readback shifter, end of frame strobe
 */
module spi_frame_rx (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            sclk_rise,
  input  logic            sclk_fall,
  input  logic            cs_rise,
  input  logic            cs_q,
  input  logic            special_q,
  input  logic            mosi_q,
  input  logic [3:0]      rd_nibble,
  output logic [7:0]      addr_peek,
  output logic            sdo,
  output smu_pkg::frame_t frame,
  output logic            frame_valid
);

  import smu_pkg::*;

  localparam int ADDR_BITS = 8;
  // one spare count above a full frame, so long frames never wrap to full
  localparam int CNT_W = $clog2(FRAME_BITS + 2);
  localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(FRAME_BITS + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_PEEK = CNT_W'(ADDR_BITS - 1);

  frame_t           shift_q;
  logic [CNT_W-1:0] bit_cnt;
  logic             peek_load_q;
  logic [7:0]       rb_q;
  logic             active;

  // controller selected: cs low and special low
  assign active = ~cs_q & ~special_q;

  ////////////////////
  // receive

  // msb first, new bit in at the lsb
  always_ff @(posedge clk)
  begin
    if (sclk_rise && active)
      shift_q.raw <= {shift_q.raw[FRAME_BITS-2:0], mosi_q};
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      bit_cnt <= '0;
    else if (cs_q)
      bit_cnt <= '0;
    else if (sclk_rise && active && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // after eight bits the low byte of the shifter is the address
  assign addr_peek = shift_q.raw[ADDR_BITS-1:0];

  ////////////////////
  // readback

  // pulse in the cycle after the eighth bit lands
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      peek_load_q <= 1'b0;
    else
      peek_load_q <= sclk_rise && active && (bit_cnt == CNT_PEEK);
  end

  // only the low byte is shifted out, the high byte went out as zeros
  // during the address phase
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rb_q <= '0;
    else if (cs_q)
      rb_q <= '0;
    else if (peek_load_q)
      rb_q <= {4'h0, rd_nibble};
    else if (sclk_fall)
      rb_q <= {rb_q[6:0], 1'b0};
  end

  // sdo changes on the fall, master samples on the next rise
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sdo <= 1'b0;
    else if (cs_q)
      sdo <= 1'b0;
    else if (sclk_fall)
      sdo <= rb_q[7];
  end

  ////////////////////
  // end of frame

  // short or long frames are dropped here
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && (bit_cnt == CNT_FULL);
  end

  // shifter is quiet while cs is high, so it holds through the update
  assign frame = shift_q;

  a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |=> !frame_valid)
    else $error("frame_valid held longer than one cycle");

endmodule

//--- spi_front/spi_sync.sv
/*
 * input synchronizers for sclk, cs, special and mosi
 * sclk rise/fall and cs rise edge pulses
 */
module spi_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sclk,
  input  logic cs,
  input  logic special,
  input  logic mosi,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic cs_rise,
  output logic cs_q,
  output logic special_q,
  output logic mosi_q
);

  // the four pins travel down the chain together
  typedef struct packed {
    logic sclk;
    logic cs;
    logic special;
    logic mosi;
  } spi_pins_t;

  spi_pins_t                   pins;
  spi_pins_t [SYNC_STAGES-1:0] sync_q;
  spi_pins_t                   last;
  logic                        sclk_d;
  logic                        cs_d;

  assign pins = '{sclk: sclk, cs: cs, special: special, mosi: mosi};
  assign last = sync_q[SYNC_STAGES-1];

  ////////////////////
  // flop chain

  // reset to all ones
  // cs idles high so no false end of frame follows reset
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sync_q <= '1;
    else
      sync_q <= {sync_q[SYNC_STAGES-2:0], pins};
  end

  ////////////////////
  // edge detect

  // one extra flop behind the last stage
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_d <= 1'b1;
      cs_d   <= 1'b1;
    end
    else
    begin
      sclk_d <= last.sclk;
      cs_d   <= last.cs;
    end
  end

  assign sclk_rise = last.sclk & ~sclk_d;
  assign sclk_fall = ~last.sclk & sclk_d;
  // chip select deassert marks the end of frame
  assign cs_rise   = last.cs & ~cs_d;

  assign cs_q      = last.cs;
  assign special_q = last.special;
  assign mosi_q    = last.mosi;

  // the master only clocks sclk while it holds cs low
  a_sclk_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
    sclk_rise |-> !cs_q)
    else $error("sclk rose while chip select was high");

endmodule

//--- tb.f
common/smu_pkg.sv
spi_front/spi_sync.sv
spi_front/spi_frame_rx.sv
source/reg_bank.sv
source/spi_route.sv
source/smu_ctrl_top.sv
testbench/smu_checker.sv
testbench/tb_smu_ctrl.sv

//--- testbench/smu_checker.sv
/*
 * testbench checker for the smu spi front end
 * readback, cs fan-out, routed miso and control register compares
 */
module smu_checker (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         sclk,
  input  logic                         cs,
  input  logic                         miso,
  input  logic [smu_pkg::N_PERIPH-1:0] cs_vec,
  input  logic [smu_pkg::N_PERIPH-1:0] miso_vec,
  input  smu_pkg::ctrl_regs_t          ctrl,
  input  logic                         exp_special,
  input  int                           exp_nbits,
  input  logic [15:0]                  exp_readback,
  input  smu_pkg::ctrl_regs_t          exp_ctrl,
  input  logic [smu_pkg::N_PERIPH-1:0] exp_cs_vec,
  output int                           mismatches,
  output int                           timeouts,
  output int                           frames_done
);

  timeunit 1ns;
  timeprecision 100ps;

  import smu_pkg::*;

  // power-on value with clamps and irange off and rails_oe 0001
  localparam logic [39:0] RESET_CTRL  = 40'h000000fff1;
  localparam int          RESET_LIMIT = 50;
  localparam int          IDLE_LIMIT  = 400;
  localparam int          FRAME_LIMIT = 600;
  localparam int          CTRL_LIMIT  = 20;
  // mid-frame point for the cs_vec sample
  localparam int          CS_SAMPLE   = 8;

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // idle chip select

  // no peripheral selected while cs is high
  always @(posedge clk)
  begin
    if (arst_n === 1'b1 && cs === 1'b1 && cs_vec !== 4'hf)
      report_mismatch($sformatf("cs_vec %h while cs high, expected f", cs_vec));
  end

  ////////////////////
  // per frame compare

  initial
  begin
    int          n;
    int          rises;
    logic        sclk_prev;
    logic [15:0] shifted;
    logic        exp_miso;
    mismatches  = 0;
    timeouts    = 0;
    frames_done = 0;
    n = 0;
    while (arst_n !== 1'b1 && n < RESET_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (arst_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      timeouts++;
    end
    @(posedge clk);
    if (ctrl !== RESET_CTRL)
      report_mismatch($sformatf("ctrl after reset %h, expected %h", ctrl, RESET_CTRL));
    forever
    begin
      // wait for cs low
      n = 0;
      while (cs !== 1'b0 && n < IDLE_LIMIT)
      begin
        @(posedge clk);
        n++;
      end
      if (cs !== 1'b0)
      begin
        $display("timeout: no frame started within %0d cycles", IDLE_LIMIT);
        timeouts++;
      end
      else
      begin
        rises     = 0;
        shifted   = 16'h0000;
        sclk_prev = sclk;
        n = 0;
        // sclk changes on the falling clk edge and is settled here
        while (cs === 1'b0 && n < FRAME_LIMIT)
        begin
          @(posedge clk);
          n++;
          if (sclk === 1'b1 && sclk_prev === 1'b0)
          begin
            rises++;
            shifted = {shifted[14:0], miso};
            if (rises == CS_SAMPLE && cs_vec !== exp_cs_vec)
              report_mismatch($sformatf("cs_vec %h, expected %h", cs_vec, exp_cs_vec));
            // routed miso is the or over the selected peripherals
            if (exp_special)
            begin
              exp_miso = |(exp_ctrl.mux & miso_vec);
              if (miso !== exp_miso)
                report_mismatch($sformatf("routed miso %b, expected %b (mux %h vec %h)",
                                          miso, exp_miso, exp_ctrl.mux, miso_vec));
            end
          end
          sclk_prev = sclk;
        end
        if (cs === 1'b0)
        begin
          $display("timeout: frame still running after %0d cycles", FRAME_LIMIT);
          timeouts++;
        end
        if (rises != exp_nbits)
          report_mismatch($sformatf("%0d sclk rises, expected %0d", rises, exp_nbits));
        // readback has a zero high byte and the old register value below
        if (!exp_special && shifted !== exp_readback)
          report_mismatch($sformatf("readback %h, expected %h", shifted, exp_readback));
        n = 0;
        while (ctrl !== exp_ctrl && n < CTRL_LIMIT)
        begin
          @(posedge clk);
          n++;
        end
        if (ctrl !== exp_ctrl)
          report_mismatch($sformatf("ctrl %h, expected %h", ctrl, exp_ctrl));
        else
        begin
          // the update lands a few clk after cs rises
          // so ctrl must hold for the rest of the window
          while (ctrl === exp_ctrl && n < CTRL_LIMIT)
          begin
            @(posedge clk);
            n++;
          end
          if (ctrl !== exp_ctrl)
            report_mismatch($sformatf("ctrl moved to %h, expected to stay %h",
                                      ctrl, exp_ctrl));
        end
        frames_done++;
      end
    end
  end

endmodule

//--- testbench/smu_golden.txt
# special nbits(dec) word miso_mask readback ctrl cs_vec, the rest hex
# ctrl nibbles: led mux dac rails dac_ref_mux adc clamp1 clamp2 irange_sense rails_oe
0 16 0705 0 0000 500000fff1 f
0 16 0803 0 0000 530000fff1 f
0 16 090a 0 0000 53a000fff1 f
0 16 0a0f 0 0000 53af00fff1 f
0 16 0a60 0 000f 53a900fff1 f
0 16 0742 0 0005 33a900fff1 f
0 16 0d0f 0 0000 33a900fff1 f
0 16 0f30 0 000f 33a900cff1 f
0 16 1466 0 000f 33a900cf91 f
0 16 1466 0 0009 33a900cff1 f
0 16 0c13 0 0000 33a910cff1 f
0 16 0c13 0 0001 33a900cff1 f
0 16 0e0c 0 0000 33a90ccff1 f
0 16 10f0 0 000f 33a90cc0f1 f
0 16 1816 0 0001 33a90cc0f6 f
0 16 0800 0 0003 33a90cc0f6 f
1 16 a5a5 f 0000 33a90cc0f6 c
1 16 1234 4 0000 33a90cc0f6 c
0 16 0839 0 0003 32a90cc0f6 f
1 16 5a5a f 0000 32a90cc0f6 d
0 12 07f0 0 0000 32a90cc0f6 f
0 16 0b00 0 0000 000000fff1 f
0 16 0800 0 0000 000000fff1 f
1 16 ffff f 0000 000000fff1 f
0 16 1800 0 0001 000000fff1 f

//--- testbench/tb_smu_ctrl.sv
/*
 * testbench top for the smu spi front end
 * clock, reset, spi master replaying frames from the golden file
 */
module tb_smu_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  import smu_pkg::*;

  // clk cycles per sclk half period
  localparam int    HALF_SCLK  = 8;
  // clk cycles allowed for the checker to close a frame
  localparam int    DONE_LIMIT = 100;
  localparam string GOLDEN     = "testbench/smu_golden.txt";

  logic                clk;
  logic                arst_n;
  logic                sclk;
  logic                cs;
  logic                special;
  logic                mosi;
  logic                miso;
  logic [N_PERIPH-1:0] cs_vec;
  logic [N_PERIPH-1:0] miso_vec;
  ctrl_regs_t          ctrl;

  // expectations handed to the checker
  logic                exp_special;
  int                  exp_nbits;
  logic [15:0]         exp_readback;
  ctrl_regs_t          exp_ctrl;
  logic [N_PERIPH-1:0] exp_cs_vec;

  // error counts and progress
  int                  mismatches;
  int                  chk_timeouts;
  int                  frames_done;
  int                  timeouts;
  int                  file_errors;
  int                  frames_sent;
  logic [31:0]         lcg_state;

  smu_ctrl_top #(
    .SYNC_STAGES (2)
  ) UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .sclk     (sclk),
    .cs       (cs),
    .special  (special),
    .mosi     (mosi),
    .miso     (miso),
    .cs_vec   (cs_vec),
    .miso_vec (miso_vec),
    .ctrl     (ctrl)
  );

  smu_checker u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .sclk         (sclk),
    .cs           (cs),
    .miso         (miso),
    .cs_vec       (cs_vec),
    .miso_vec     (miso_vec),
    .ctrl         (ctrl),
    .exp_special  (exp_special),
    .exp_nbits    (exp_nbits),
    .exp_readback (exp_readback),
    .exp_ctrl     (exp_ctrl),
    .exp_cs_vec   (exp_cs_vec),
    .mismatches   (mismatches),
    .timeouts     (chk_timeouts),
    .frames_done  (frames_done)
  );

  // 20 ns period
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // helpers

  // lcg step with seed 94 set in the main sequence
  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // mode 0 master shifting msb first
  // mosi and routed miso_vec change with the sclk fall
  task automatic shift_frame(
    input logic        spec,
    input int          nbits,
    input logic [15:0] word,
    input logic [3:0]  mask
  );
    int i;
    cs = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      mosi = word[FRAME_BITS-1-i];
      // routed bits get fresh peripheral miso masked by the golden column
      if (spec)
      begin
        lcg_state = next_random(lcg_state);
        miso_vec  = lcg_state[19:16] & mask;
      end
      idle_cycles(HALF_SCLK);
      sclk = 1'b1;
      idle_cycles(HALF_SCLK);
      sclk = 1'b0;
    end
    idle_cycles(HALF_SCLK);
    cs = 1'b1;
  endtask

  // checker bumps frames_done once ctrl has been compared
  task automatic wait_checked(input int target);
    int n;
    n = 0;
    while (frames_done < target && n < DONE_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (frames_done < target)
    begin
      $display("timeout: checker did not finish frame %0d", target);
      timeouts++;
    end
  endtask

  task automatic play_frame(
    input logic        spec,
    input int          nbits,
    input logic [15:0] word,
    input logic [3:0]  mask,
    input logic [15:0] rb,
    input logic [39:0] ctrl_val,
    input logic [3:0]  csv
  );
    @(negedge clk);
    exp_special  = spec;
    exp_nbits    = nbits;
    exp_readback = rb;
    exp_ctrl     = ctrl_val;
    exp_cs_vec   = csv;
    special      = spec;
    miso_vec     = 4'h0;
    idle_cycles(2);
    shift_frame(spec, nbits, word, mask);
    frames_sent++;
    wait_checked(frames_sent);
    // cs high for at least four clk before the next frame
    idle_cycles(4);
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    int          fd;
    string       line;
    int          nread;
    logic [3:0]  f_spec;
    int          f_nbits;
    logic [15:0] f_word;
    logic [3:0]  f_mask;
    logic [15:0] f_rb;
    logic [39:0] f_ctrl;
    logic [3:0]  f_csv;
    arst_n       = 1'b0;
    sclk         = 1'b0;
    cs           = 1'b1;
    special      = 1'b0;
    mosi         = 1'b0;
    miso_vec     = 4'h0;
    exp_special  = 1'b0;
    exp_nbits    = 0;
    exp_readback = 16'h0000;
    exp_ctrl     = '0;
    exp_cs_vec   = 4'hf;
    timeouts     = 0;
    file_errors  = 0;
    frames_sent  = 0;
    lcg_state    = 32'd94;
    // reset for 4 clk cycles
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    idle_cycles(4);
    fd = $fopen(GOLDEN, "r");
    if (fd == 0)
    begin
      $display("could not open %s", GOLDEN);
      file_errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        // skip comment lines
        if (line.len() > 0 && line[0] != "#")
        begin
          nread = $sscanf(line, "%h %d %h %h %h %h %h",
                          f_spec, f_nbits, f_word, f_mask, f_rb, f_ctrl, f_csv);
          if (nread == 7)
            play_frame(f_spec[0], f_nbits, f_word, f_mask, f_rb, f_ctrl, f_csv);
          else if (nread > 0)
          begin
            $display("golden file line could not be read: %s", line);
            file_errors++;
          end
        end
      end
      $fclose(fd);
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d file errors, %0d frames run",
             mismatches, timeouts + chk_timeouts, file_errors, frames_sent);
    if (mismatches == 0 && timeouts + chk_timeouts == 0 && file_errors == 0 && frames_sent > 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
